//--- source/secp256k1_pkg.sv
/*
  Shared constants and types for the secp256k1 field multiplier.
  Field elements are plain 256-bit vectors and are not range checked here.
  A product is one 512-bit word, read either flat or as two 256-bit halves.
*/

package secp256k1_pkg;

  // Field prime p = 2^256 - 2^32 - 977.
  localparam logic [255:0] P_EQ = {
    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 32'hFFFF_FC2F
  };

  // 2^256 mod p, so a high half folds down as hi * FOLD_C.
  localparam logic [32:0] FOLD_C = 33'h1_0000_03D1;

  // Register stages per block.
  localparam int MULT_LAT = 2;
  localparam int MOD_LAT  = 3;

  // One field element or operand.
  typedef logic [255:0] fe_t;

  // Operand pair, a in the upper half.
  typedef struct packed {
    fe_t a;
    fe_t b;
  } op_t;

  // Product split for folding.
  typedef struct packed {
    fe_t hi;
    fe_t lo;
  } prod_half_t;

  // Same 512 bits, flat for compares or halved for folds.
  typedef union packed {
    logic [511:0] flat;
    prod_half_t   half;
  } prod_u;

endpackage

//--- source/secp256k1_mult.sv
/*
  Two-stage 256x256 integer multiplier from four 128x128 partial products.
  Full 512-bit product, no reduction. Both stages load only while i_en is high,
  so a low i_en freezes every register in place. No input buffering exists,
  and the caller holds its beat while i_en is low.
*/

module secp256k1_mult
  import secp256k1_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  op_t   i_op,
  input  logic  i_val,
  input  logic  i_err,
  input  logic  i_en,
  output prod_u o_prod,
  output logic  o_val,
  output logic  o_err
);

  // Partial products of the operand halves.
  typedef struct packed {
    logic [255:0] ll;
    logic [255:0] lh;
    logic [255:0] hl;
    logic [255:0] hh;
  } pp_t;

  // Operand halves.
  logic [127:0] a_lo;
  logic [127:0] a_hi;
  logic [127:0] b_lo;
  logic [127:0] b_hi;

  // Stage 1 result and registers.
  pp_t  pp_d;
  pp_t  pp_q;
  logic val_q;
  logic err_q;

  // Stage 2 sum.
  prod_u sum;

  always_comb begin
    a_lo = i_op.a[127:0];
    a_hi = i_op.a[255:128];
    b_lo = i_op.b[127:0];
    b_hi = i_op.b[255:128];
  end

  // Each product is exact in 256 bits.
  always_comb begin
    pp_d.ll = a_lo * b_lo;
    pp_d.lh = a_lo * b_hi;
    pp_d.hl = a_hi * b_lo;
    pp_d.hh = a_hi * b_hi;
  end

  // Stage 1 data.
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      pp_q <= pp_d;
    end
  end

  // Stage 1 control.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= 1'b0;
      err_q <= 1'b0;
    end else if (i_en) begin
      val_q <= i_val;
      err_q <= i_err;
    end
  end

  // hh and ll do not overlap, so they simply concatenate.
  // Cross terms land at bit 128.
  always_comb begin
    sum.flat = {pp_q.hh, pp_q.ll}
             + (512'(pp_q.lh) << 128)
             + (512'(pp_q.hl) << 128);
  end

  // Stage 2 data.
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_prod <= sum;
    end
  end

  // Stage 2 control.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (i_en) begin
      o_val <= val_q;
      o_err <= err_q;
    end
  end

  // Output frozen over a stall cycle.
  a_hold_on_stall: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !i_en |=> $stable(o_val) && $stable(o_prod)
  ) else $error("multiplier output moved while i_en low");

endmodule

//--- source/secp256k1_mod.sv
/*
  Reduces a 512-bit product modulo the secp256k1 prime in three stages.
  Two folds by 2^256 mod p, then one conditional subtract of p.
  Exact for any input below 2^512. o_err flags a residue still at or above 2p,
  which cannot occur for such inputs, or an error carried in with the beat.
  USE_MULT = 1 folds with a constant multiply; 0 uses shifts and adds.
*/

module secp256k1_mod
  import secp256k1_pkg::*;
#(
  parameter int USE_MULT = 0
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  prod_u i_prod,
  input  logic  i_val,
  input  logic  i_err,
  input  logic  i_rdy,
  output fe_t   o_dat,
  output logic  o_val,
  output logic  o_err
);

  // Fold results of stage 1 and stage 2.
  prod_u res0;
  prod_u res1;

  // Valid and error, one bit per stage.
  logic [1:0] val;
  logic [1:0] err;

  // Final compare results.
  logic ge_p;
  logic ge_2p;

  // hi * FOLD_C + lo.
  function automatic prod_u fold(prod_u x);
    prod_u r;
    r.flat = 512'(x.half.lo);
    if (USE_MULT == 1) begin
      // Constant multiply, maps onto DSP blocks.
      r.flat = r.flat + 512'(x.half.hi) * 512'(FOLD_C);
    end else begin
      // One shifted copy of hi per set bit of FOLD_C.
      for (int i = 0; i < $bits(FOLD_C); i++) begin
        if (FOLD_C[i]) begin
          r.flat = r.flat + (512'(x.half.hi) << i);
        end
      end
    end
    return r;
  endfunction

  // Stage 1 leaves under 2^290.
  // Stage 2 leaves under 2^256 + 2^67.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      res0 <= fold(i_prod);
      res1 <= fold(res0);
    end
  end

  always_comb begin
    ge_p  = res1.flat >= 512'(P_EQ);
    ge_2p = res1.flat >= 512'({P_EQ, 1'b0});
  end

  // Stage 3 data, one subtract is enough below 2p.
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      o_dat <= ge_p ? fe_t'(res1.flat - 512'(P_EQ)) : res1.half.lo;
    end
  end

  // Control shifts alongside the data.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val   <= '0;
      err   <= '0;
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (i_rdy) begin
      val   <= {val[0], i_val};
      err   <= {err[0], i_err};
      o_val <= val[1];
      // Range check only on a live beat.
      o_err <= err[1] || (val[1] && ge_2p);
    end
  end

  // A clean result is a reduced field element.
  a_reduced: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_val && !o_err |-> o_dat < P_EQ
  ) else $error("clean result not below p");

  // Outputs frozen while downstream stalls.
  a_hold_on_stall: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !i_rdy |=> $stable(o_dat) && $stable(o_val) && $stable(o_err)
  ) else $error("reducer output moved while i_rdy low");

endmodule

//--- source/secp256k1_mod_mult.sv
/*
  Pipelined multiply modulo the secp256k1 prime, five stages deep.
  A beat moves on a rising edge with val and i_rdy both high.
  A low i_rdy stalls every stage, so upstream must hold its beat.
  o_rdy is i_rdy itself. Operands at or above p are reduced as well.
*/

module secp256k1_mod_mult
  import secp256k1_pkg::*;
#(
  parameter int USE_MULT = 0
) (
  input  logic i_clk,
  input  logic i_rst,
  input  op_t  i_op,
  input  logic i_val,
  input  logic i_err,
  output logic o_rdy,
  output fe_t  o_dat,
  output logic o_val,
  output logic o_err,
  input  logic i_rdy
);

  // Multiplier to reducer.
  prod_u prod;
  logic  prod_val;
  logic  prod_err;

  // Whole pipe moves in lockstep, so no skid buffer.
  assign o_rdy = i_rdy;

  secp256k1_mult u_secp256k1_mult (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_op   (i_op),
    .i_val  (i_val),
    .i_err  (i_err),
    .i_en   (i_rdy),
    .o_prod (prod),
    .o_val  (prod_val),
    .o_err  (prod_err)
  );

  secp256k1_mod #(
    .USE_MULT (USE_MULT)
  ) u_secp256k1_mod (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_prod (prod),
    .i_val  (prod_val),
    .i_err  (prod_err),
    .i_rdy  (i_rdy),
    .o_dat  (o_dat),
    .o_val  (o_val),
    .o_err  (o_err)
  );

  // Accepted beat shows up after the full depth of enabled cycles.
  a_latency: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (i_val && i_rdy) ##1 i_rdy [* (MULT_LAT + MOD_LAT - 1)] |=> o_val
  ) else $error("accepted beat missing at output after pipeline depth");

endmodule

//--- tests/secp256k1_model.svh
/*
  Reference model for the secp256k1 field multiplier testbench.
  Uses plain wide-integer multiply and remainder, valid for any 256-bit operands.
  Expects fe_t and P_EQ to be visible where it is included.
*/

`ifndef SECP256K1_MODEL_SVH
`define SECP256K1_MODEL_SVH

// Expected output of one beat.
typedef struct packed {
  fe_t  dat;
  logic err;
} res_t;

// Full product, then one remainder by p.
function automatic res_t model_mod_mult(fe_t a, fe_t b, logic err);
  logic [511:0] prod;
  res_t         r;
  prod  = 512'(a) * 512'(b);
  r.dat = fe_t'(prod % 512'(P_EQ));
  // No residue of a real product reaches 2p.
  r.err = err;
  return r;
endfunction

// 2^256 mod p, derived from the prime alone.
function automatic fe_t model_fold_const();
  logic [511:0] two_256;
  two_256 = 512'(1) << 256;
  return fe_t'(two_256 % 512'(P_EQ));
endfunction

// Operands near 2^256 - 2^32, plus the trivial ones.
// Index 7 and above give no fixed value.
function automatic fe_t edge_value(int idx);
  case (idx)
    0:       return '0;
    1:       return 256'd1;
    2:       return P_EQ - 256'd1;
    3:       return P_EQ + 256'd977;
    4:       return P_EQ + 256'd976;
    5:       return P_EQ + 256'd978;
    6:       return P_EQ;
    default: return '1;
  endcase
endfunction

`endif

//--- tests/secp256k1_mod_mult_tb.sv
/*
  Testbench for the pipelined secp256k1 field multiplier.
  Random and edge operands, error flags and random stalls on i_rdy.
  Every output beat is matched in order against the model, and its arrival
  is checked against a fixed depth of 5 enabled cycles.
*/

module secp256k1_mod_mult_tb
  import secp256k1_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "secp256k1_model.svh"

  // Beat kinds for stimulus.
  localparam int KIND_RAND = 0;
  localparam int KIND_EDGE = 1;
  localparam int KIND_ERR  = 2;

  // Enabled cycles from acceptance to transfer.
  localparam int PIPE_DEPTH = 5;

  logic clk = 1'b0;
  logic rst;
  op_t  op;
  logic in_val;
  logic in_err;
  logic out_rdy;
  fe_t  out_dat;
  logic out_val;
  logic out_err;
  logic in_rdy;

  int seed = 32'h0c112bae;

  // Scoreboard, expected results and their due enabled cycle.
  res_t exp_q[$];
  int   due_q[$];
  int   en_idx = 0;
  int   n_in = 0;
  int   n_out = 0;

  int fe_errs = 0;
  int bit_errs = 0;
  int other_errs = 0;

  secp256k1_mod_mult #(
    .USE_MULT (0)
  ) u_secp256k1_mod_mult (
    .i_clk (clk),
    .i_rst (rst),
    .i_op  (op),
    .i_val (in_val),
    .i_err (in_err),
    .o_rdy (out_rdy),
    .o_dat (out_dat),
    .o_val (out_val),
    .o_err (out_err),
    .i_rdy (in_rdy)
  );

  always #10 clk = ~clk;

  function automatic int pick(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Random element below p.
  function automatic fe_t rand_fe();
    fe_t v;
    for (int i = 0; i < 8; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    if (v >= P_EQ) begin
      v = v - P_EQ;
    end
    return v;
  endfunction

  function automatic fe_t edge_operand(int idx);
    return (idx < 7) ? edge_value(idx) : rand_fe();
  endfunction

  // Edge beats walk all 64 operand pairs.
  function automatic op_t make_op(int kind, int idx);
    op_t o;
    if (kind == KIND_EDGE) begin
      o.a = edge_operand(idx % 8);
      o.b = edge_operand((idx / 8) % 8);
    end else begin
      o.a = rand_fe();
      o.b = rand_fe();
    end
    return o;
  endfunction

  task automatic check_fe(input string name, input fe_t got, input fe_t want);
    if (got !== want) begin
      fe_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      bit_errs++;
      $display("ERR %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  // Scoreboard and occupancy checks, sampled on the edge itself.
  always @(posedge clk) begin
    res_t want;
    logic want_val;
    if (!rst) begin
      // o_rdy is a straight copy of i_rdy.
      check_bit("o_rdy", out_rdy, in_rdy);
      // Output valid exactly when the oldest beat is due.
      want_val = (due_q.size() > 0) && (due_q[0] == en_idx);
      check_bit("o_val", out_val, want_val);
      if (!want_val) begin
        check_bit("o_err", out_err, 1'b0);
      end
      if (out_val && want_val && in_rdy) begin
        want = exp_q.pop_front();
        void'(due_q.pop_front());
        check_fe("o_dat", out_dat, want.dat);
        check_bit("o_err", out_err, want.err);
        n_out++;
      end
      if (in_val && in_rdy) begin
        exp_q.push_back(model_mod_mult(op.a, op.b, in_err));
        due_q.push_back(en_idx + PIPE_DEPTH);
        n_in++;
      end
      if (in_rdy) begin
        en_idx++;
      end
    end
  end

  // A held beat changes only once it has been taken.
  task automatic send_beats(input int count, input int kind, input int rdy_pct,
                            input int gap_pct);
    int sent;
    int cycles;
    int limit;
    sent   = 0;
    cycles = 0;
    limit  = count * 20 + 100;
    while (sent < count && cycles < limit) begin
      @(posedge clk);
      cycles++;
      if (in_val && in_rdy) begin
        sent++;
      end
      if (!in_val || in_rdy) begin
        if (sent < count && pick(100) >= gap_pct) begin
          op     <= make_op(kind, sent);
          in_val <= 1'b1;
          in_err <= (kind == KIND_ERR) ? 1'(pick(2)) : 1'b0;
        end else begin
          in_val <= 1'b0;
          in_err <= 1'b0;
        end
      end
      in_rdy <= (pick(100) < rdy_pct);
    end
    if (sent < count) begin
      other_errs++;
      $display("Timed out sending beats, %0d of %0d accepted", sent, count);
    end
  endtask

  // Open the pipe and wait for every beat in flight.
  task automatic drain();
    int cycles;
    int limit;
    cycles = 0;
    limit  = (MULT_LAT + MOD_LAT) * 4 + 20;
    @(posedge clk);
    in_val <= 1'b0;
    in_err <= 1'b0;
    in_rdy <= 1'b1;
    while (due_q.size() > 0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (due_q.size() > 0) begin
      other_errs++;
      $display("Timed out draining, %0d results never arrived", due_q.size());
    end
  endtask

  initial begin
    rst    <= 1'b1;
    op     <= '0;
    in_val <= 1'b0;
    in_err <= 1'b0;
    in_rdy <= 1'b0;
    check_fe("FOLD_C", fe_t'(FOLD_C), model_fold_const());
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    in_rdy <= 1'b1;
    // Back to back with i_rdy held high.
    send_beats(40, KIND_RAND, 100, 0);
    drain();
    send_beats(64, KIND_EDGE, 100, 10);
    drain();
    send_beats(60, KIND_ERR, 80, 20);
    drain();
    // Heavy back-pressure.
    send_beats(200, KIND_RAND, 50, 25);
    drain();
    $display("Errors: data %0d, flag %0d, other %0d; beats in %0d, out %0d",
             fe_errs, bit_errs, other_errs, n_in, n_out);
    if (fe_errs + bit_errs + other_errs == 0 && n_in == n_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- secp256k1_mod_mult.f
+incdir+tests
source/secp256k1_pkg.sv
source/secp256k1_mult.sv
source/secp256k1_mod.sv
source/secp256k1_mod_mult.sv
tests/secp256k1_mod_mult_tb.sv

//--- Bender.yml
package:
  name: secp256k1_mod_mult

sources:
  # Package first, then leaf blocks, then the top level.
  - source/secp256k1_pkg.sv
  - source/secp256k1_mult.sv
  - source/secp256k1_mod.sv
  - source/secp256k1_mod_mult.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/secp256k1_mod_mult_tb.sv
